// ==== hdl/alu_datapath_config.svh ====
`ifndef ALU_DATAPATH_CONFIG_SVH
`define ALU_DATAPATH_CONFIG_SVH

// width of the shared bus and both operand registers
`define DATA_W 8

// bus requesters, alu first then host
`define NUM_SRC 2

`endif

// ==== hdl/alu_datapath_pkg.sv ====
`include "alu_datapath_config.svh"

package alu_datapath_pkg;

    typedef logic [`DATA_W-1:0] data_t;

    typedef enum logic [1:0] {
        ADD = 2'd0,
        SUB = 2'd1,
        AND = 2'd2,
        OR  = 2'd3
    } alu_op_t;

    // target of a host write
    typedef enum logic {
        DEST_A = 1'b0,
        DEST_B = 1'b1
    } dest_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        logic  valid;
        dest_t dest;
        data_t data;
    } host_req_t;

    // arith marks ADD or SUB, the only ops that own c and v
    typedef struct packed {
        logic  valid;
        data_t result;
        logic  carry;
        logic  overflow;
        logic  arith;
    } alu_req_t;

    // one transfer on the shared internal bus
    typedef struct packed {
        logic  valid;
        logic  from_alu;
        dest_t dest;
        data_t data;
        logic  carry;
        logic  overflow;
        logic  arith;
    } bus_xfer_t;

endpackage

// ==== hdl/bus_arbiter.sv ====
`include "alu_datapath_config.svh"

module bus_arbiter import alu_datapath_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  host_req_t host_req,
    input  alu_req_t  alu_req,
    output bus_xfer_t bus
);

    host_req_t           host_q;
    host_req_t           pend;
    host_req_t           pend_nxt;
    host_req_t           host_sel;
    bus_xfer_t           bus_nxt;
    logic [`NUM_SRC-1:0] req;
    logic [`NUM_SRC-1:0] gnt;

    // bit 0 is the alu, bit 1 the host side (pending slot or new strobe)
    assign req = {pend.valid | host_q.valid, alu_req.valid};

    // lowest set bit wins
    assign gnt = req & (~req + 1'b1);

    // a parked write goes ahead of a fresh one
    assign host_sel = pend.valid ? pend : host_q;

    always_comb begin
        bus_nxt  = '0;
        pend_nxt = pend;
        if (gnt[0]) begin
            bus_nxt.valid    = 1'b1;
            bus_nxt.from_alu = 1'b1;
            bus_nxt.dest     = DEST_A;
            bus_nxt.data     = alu_req.result;
            bus_nxt.carry    = alu_req.carry;
            bus_nxt.overflow = alu_req.overflow;
            bus_nxt.arith    = alu_req.arith;
            // losing host write parks, dropped if the slot is taken
            if (host_q.valid && !pend.valid) begin
                pend_nxt = host_q;
            end
        end else if (gnt[1]) begin
            bus_nxt.valid = 1'b1;
            bus_nxt.dest  = host_sel.dest;
            bus_nxt.data  = host_sel.data;
            if (pend.valid && host_q.valid) begin
                pend_nxt = host_q;
            end else begin
                pend_nxt.valid = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        host_q <= host_req;
        pend   <= pend_nxt;
        bus    <= bus_nxt;
        if (rst) begin
            host_q.valid <= 1'b0;
            pend.valid   <= 1'b0;
            bus.valid    <= 1'b0;
        end
    end

endmodule

// ==== hdl/register_file.sv ====
module register_file import alu_datapath_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  bus_xfer_t bus,
    output data_t     reg_a,
    output data_t     reg_b
);

    logic wr_a;
    logic wr_b;

    // alu results always carry DEST_A, so one decode covers both sources
    assign wr_a = bus.valid && (bus.dest == DEST_A);
    assign wr_b = bus.valid && (bus.dest == DEST_B);

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_a <= '0;
        end else if (wr_a) begin
            reg_a <= bus.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_b <= '0;
        end else if (wr_b) begin
            reg_b <= bus.data;
        end
    end

endmodule

// ==== hdl/alu.sv ====
`include "alu_datapath_config.svh"

module alu import alu_datapath_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     alu_go,
    input  alu_op_t  alu_op,
    input  data_t    reg_a,
    input  data_t    reg_b,
    output alu_req_t alu_req
);

    logic             go_q;
    alu_op_t          op_q;
    data_t            a_q;
    data_t            b_q;
    logic             is_sub;
    data_t            b_eff;
    logic [`DATA_W:0] sum;
    alu_req_t         req_nxt;

    // operands frozen at the issue edge, so back-to-back ops stay independent
    always_ff @(posedge clk) begin
        op_q <= alu_op;
        a_q  <= reg_a;
        b_q  <= reg_b;
        if (rst) begin
            go_q <= 1'b0;
        end else begin
            go_q <= alu_go;
        end
    end

    // subtract as a plus not b plus one, carry out of 1 means no borrow
    assign is_sub = (op_q == SUB);
    assign b_eff  = is_sub ? ~b_q : b_q;
    assign sum    = {1'b0, a_q} + {1'b0, b_eff} + is_sub;

    always_comb begin
        req_nxt       = '0;
        req_nxt.valid = go_q;
        unique case (op_q)
            ADD, SUB: begin
                req_nxt.result   = sum[`DATA_W-1:0];
                req_nxt.carry    = sum[`DATA_W];
                // same-sign inputs, result sign flipped
                req_nxt.overflow = (a_q[`DATA_W-1] == b_eff[`DATA_W-1]) &&
                                   (sum[`DATA_W-1] != a_q[`DATA_W-1]);
                req_nxt.arith    = 1'b1;
            end
            AND: req_nxt.result = a_q & b_q;
            OR:  req_nxt.result = a_q | b_q;
        endcase
    end

    always_ff @(posedge clk) begin
        alu_req <= req_nxt;
        if (rst) begin
            alu_req.valid <= 1'b0;
        end
    end

endmodule

// ==== hdl/flags_reg.sv ====
`include "alu_datapath_config.svh"

module flags_reg import alu_datapath_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  bus_xfer_t bus,
    output flags_t    flags,
    output logic      result_done
);

    logic alu_xfer;

    // host loads pass over the bus without touching the flags
    assign alu_xfer = bus.valid && bus.from_alu;

    always_ff @(posedge clk) begin
        if (rst) begin
            flags       <= '0;
            result_done <= 1'b0;
        end else begin
            result_done <= alu_xfer;
            if (alu_xfer) begin
                // n and z always track the result byte
                flags.n <= bus.data[`DATA_W-1];
                flags.z <= (bus.data == '0);
                // logic ops leave c and v as the last arith op set them
                if (bus.arith) begin
                    flags.c <= bus.carry;
                    flags.v <= bus.overflow;
                end
            end
        end
    end

endmodule

// ==== hdl/alu_datapath.sv ====
module alu_datapath import alu_datapath_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  host_req_t host_req,
    input  logic      alu_go,
    input  alu_op_t   alu_op,
    output data_t     reg_a,
    output data_t     reg_b,
    output flags_t    flags,
    output logic      result_done
);

    alu_req_t  alu_req;
    bus_xfer_t bus;

    // single driver of the shared bus
    bus_arbiter bus_arbiter_i (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .alu_req  (alu_req),
        .bus      (bus)
    );

    register_file register_file_i (
        .clk   (clk),
        .rst   (rst),
        .bus   (bus),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    // reads the live registers, result comes back through the arbiter
    alu alu_i (
        .clk     (clk),
        .rst     (rst),
        .alu_go  (alu_go),
        .alu_op  (alu_op),
        .reg_a   (reg_a),
        .reg_b   (reg_b),
        .alu_req (alu_req)
    );

    flags_reg flags_reg_i (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus),
        .flags       (flags),
        .result_done (result_done)
    );

endmodule

// ==== bench/alu_datapath_assertions.sv ====
`include "alu_datapath_config.svh"

module alu_datapath_assertions import alu_datapath_pkg::*; #(
    parameter bit ARB_SIDE = 1'b0
) (
    input logic                clk,
    input logic                rst,
    input bus_xfer_t           bus,
    input logic [`NUM_SRC-1:0] req,
    input logic                pend_valid,
    input flags_t              flags,
    input logic                result_done
);

    int fail_count = 0;

    if (ARB_SIDE) begin : arb_side
        // alu and host asking together put only the alu on the bus and park the host write
        alu_first: assert property (@(posedge clk) disable iff (rst)
            (&req) |=> (bus.valid && bus.from_alu && pend_valid))
            else begin
                fail_count++;
                $error("alu and host requested together but the bus did not carry the alu alone");
            end
    end else begin : flag_side
        done_follows_xfer: assert property (@(posedge clk) disable iff (rst)
            result_done == $past(bus.valid && bus.from_alu))
            else begin
                fail_count++;
                $error("result_done out of step with the alu transfer on the bus");
            end
        // logic ops and host loads keep c and v
        cv_hold: assert property (@(posedge clk) disable iff (rst)
            (bus.valid && !bus.arith) |=> $stable({flags.c, flags.v}))
            else begin
                fail_count++;
                $error("c or v changed on a transfer without arith");
            end
    end

endmodule

bind bus_arbiter alu_datapath_assertions #(.ARB_SIDE(1'b1)) arbiter_checks (
    .clk(clk), .rst(rst), .bus(bus), .req(req), .pend_valid(pend.valid), .flags('0),
    .result_done(1'b0)
);

bind flags_reg alu_datapath_assertions #(.ARB_SIDE(1'b0)) flag_checks (
    .clk(clk), .rst(rst), .bus(bus), .req('0), .pend_valid(1'b0), .flags(flags),
    .result_done(result_done)
);

// ==== bench/alu_datapath_checker.sv ====
`include "alu_datapath_config.svh"

module alu_datapath_checker import alu_datapath_pkg::*; (
    input logic   clk,
    input data_t  reg_a,
    input data_t  reg_b,
    input flags_t flags,
    input logic   result_done
);

    localparam int WAIT_LIMIT = 16;

    int rows_run    = 0;
    int rows_bad    = 0;
    int error_count = 0;

    function automatic bit same_value(input string name, input logic [`DATA_W-1:0] expected,
                                      input logic [`DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // everything cleared, no result strobe while idle
    task automatic check_reset(input int cycles);
        bit ok;
        ok = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            ok = ok & same_value("reg_a", '0, reg_a);
            ok = ok & same_value("reg_b", '0, reg_b);
            ok = ok & same_value("flags", '0, flags);
            ok = ok & same_value("result_done", '0, result_done);
        end
        $display("reset check: %s", ok ? "ok" : "mismatch");
    endtask

    task automatic compare_row(input int row, input alu_op_t op, input data_t exp_a,
                               input data_t exp_b, input flags_t exp_flags);
        int waited;
        bit ok;
        waited = 0;
        ok = 1'b1;
        do begin
            @(negedge clk);
            waited++;
        end while (result_done !== 1'b1 && waited < WAIT_LIMIT);
        if (result_done !== 1'b1) begin
            $display("row %0d: result_done did not arrive within %0d cycles", row, WAIT_LIMIT);
            error_count++;
            ok = 1'b0;
        end else begin
            ok = ok & same_value("reg_a", exp_a, reg_a);
            ok = ok & same_value("flags", exp_flags, flags);
            // deferred host write to B lands after the result
            waited = 0;
            while (reg_b !== exp_b && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            ok = ok & same_value("reg_b", exp_b, reg_b);
        end
        rows_run++;
        if (!ok) begin
            rows_bad++;
        end
        $display("row %0d %s: %s", row, op.name(), ok ? "ok" : "mismatch");
    endtask

endmodule

// ==== bench/alu_datapath_tb.sv ====
`include "alu_datapath_config.svh"

module alu_datapath_tb import alu_datapath_pkg::*; ();

    typedef struct packed {
        data_t   a;
        data_t   b;
        alu_op_t op;
        data_t   res;
        flags_t  fl;
    } row_t;

    localparam int NUM_DIRECTED = 10;
    localparam int NUM_RANDOM   = 24;
    localparam int LOAD_LIMIT   = 16;

    logic      clk;
    logic      rst;
    host_req_t host_req;
    logic      alu_go;
    alu_op_t   alu_op;
    data_t     reg_a;
    data_t     reg_b;
    flags_t    flags;
    logic      result_done;
    row_t      rows[$];
    int        setup_fails;
    int        assert_fails;

    // a, b, op, result, {n, z, c, v}; AND/OR rows keep c and v from the row above
    row_t directed [0:NUM_DIRECTED-1] = '{
        {8'h7f, 8'h01, ADD, 8'h80, 4'b1001},
        {8'hff, 8'h01, ADD, 8'h00, 4'b0110},
        {8'hf0, 8'h0f, AND, 8'h00, 4'b0110},
        {8'h05, 8'h07, SUB, 8'hfe, 4'b1000},
        {8'h00, 8'h00, OR,  8'h00, 4'b0100},
        {8'h80, 8'h01, SUB, 8'h7f, 4'b0011},
        {8'h80, 8'h01, OR,  8'h81, 4'b1011},
        {8'h33, 8'h33, SUB, 8'h00, 4'b0110},
        {8'hc3, 8'ha5, AND, 8'h81, 4'b1010},
        {8'h80, 8'h80, ADD, 8'h00, 4'b0111}
    };

    alu_datapath alu_datapath_i (
        .clk(clk), .rst(rst), .host_req(host_req), .alu_go(alu_go), .alu_op(alu_op),
        .reg_a(reg_a), .reg_b(reg_b), .flags(flags), .result_done(result_done)
    );

    alu_datapath_checker result_chk (
        .clk(clk), .reg_a(reg_a), .reg_b(reg_b), .flags(flags), .result_done(result_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected result and flags from the ALU and flag rules
    function automatic row_t expected_row(input data_t a, input data_t b, input alu_op_t op,
                                          input flags_t prev);
        row_t             r;
        logic [`DATA_W:0] sum;
        r = {a, b, op, 8'h00, prev};
        case (op)
            ADD: begin
                sum = {1'b0, a} + {1'b0, b};
                r.res = sum[`DATA_W-1:0];
                r.fl.c = sum[`DATA_W];
                r.fl.v = (a[`DATA_W-1] == b[`DATA_W-1]) && (r.res[`DATA_W-1] != a[`DATA_W-1]);
            end
            SUB: begin
                sum = {1'b0, a} + {1'b0, ~b} + 1'b1;
                r.res = sum[`DATA_W-1:0];
                r.fl.c = sum[`DATA_W];
                r.fl.v = (a[`DATA_W-1] != b[`DATA_W-1]) && (r.res[`DATA_W-1] != a[`DATA_W-1]);
            end
            AND: r.res = a & b;
            default: r.res = a | b;
        endcase
        r.fl.n = r.res[`DATA_W-1];
        r.fl.z = (r.res == '0);
        return r;
    endfunction

    task automatic drive_host_write(input dest_t dest, input data_t value);
        @(negedge clk);
        host_req.valid = 1'b1;
        host_req.dest  = dest;
        host_req.data  = value;
        @(negedge clk);
        host_req = '0;
    endtask

    task automatic wait_operands(input data_t a, input data_t b, output bit loaded);
        int waited;
        waited = 0;
        while ((reg_a !== a || reg_b !== b) && waited < LOAD_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        loaded = (reg_a === a) && (reg_b === b);
    endtask

    initial begin
        row_t        r;
        flags_t      prev;
        bit          loaded;
        host_req    = '0;
        alu_go      = 1'b0;
        alu_op      = ADD;
        rst         = 1'b1;
        setup_fails = 0;
        void'($urandom(4259));

        foreach (directed[i]) begin
            rows.push_back(directed[i]);
        end
        prev = directed[NUM_DIRECTED-1].fl;
        // each single-bit result through OR with zero
        for (int i = 0; i < `DATA_W; i++) begin
            r = expected_row(data_t'(1 << i), '0, OR, prev);
            rows.push_back(r);
            prev = r.fl;
        end
        repeat (NUM_RANDOM) begin
            r = expected_row(data_t'($urandom_range(0, 255)), data_t'($urandom_range(0, 255)),
                             alu_op_t'($urandom_range(0, 3)), prev);
            rows.push_back(r);
            prev = r.fl;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        result_chk.check_reset(3);

        foreach (rows[i]) begin
            drive_host_write(DEST_A, rows[i].a);
            drive_host_write(DEST_B, rows[i].b);
            wait_operands(rows[i].a, rows[i].b, loaded);
            if (!loaded) begin
                $display("row %0d: operands did not reach A and B in time", i);
                setup_fails++;
            end else begin
                @(negedge clk);
                alu_go = 1'b1;
                alu_op = rows[i].op;
                @(negedge clk);
                alu_go = 1'b0;
                // this B write meets the alu result at the arbiter
                host_req.valid = 1'b1;
                host_req.dest  = DEST_B;
                host_req.data  = ~rows[i].b;
                @(negedge clk);
                host_req = '0;
                result_chk.compare_row(i, rows[i].op, rows[i].res, ~rows[i].b, rows[i].fl);
            end
        end

        assert_fails = alu_datapath_i.bus_arbiter_i.arbiter_checks.fail_count +
                       alu_datapath_i.flags_reg_i.flag_checks.fail_count;
        $display("%0d rows checked, %0d mismatched, %0d value errors, %0d load timeouts, %0d %s",
                 result_chk.rows_run, result_chk.rows_bad, result_chk.error_count,
                 setup_fails, assert_fails, "assertion failures");
        if (result_chk.error_count == 0 && result_chk.rows_bad == 0 && setup_fails == 0 &&
            assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== alu_datapath.f ====
+incdir+hdl
hdl/alu_datapath_pkg.sv
hdl/bus_arbiter.sv
hdl/register_file.sv
hdl/alu.sv
hdl/flags_reg.sv
hdl/alu_datapath.sv
bench/alu_datapath_assertions.sv
bench/alu_datapath_checker.sv
bench/alu_datapath_tb.sv

// ==== Bender.yml ====
package:
  name: alu_datapath

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/alu_datapath_pkg.sv
      - hdl/bus_arbiter.sv
      - hdl/register_file.sv
      - hdl/alu.sv
      - hdl/flags_reg.sv
      - hdl/alu_datapath.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/alu_datapath_assertions.sv
      - bench/alu_datapath_checker.sv
      - bench/alu_datapath_tb.sv
